// File: all.f
+incdir+hw
hw/fdsu_fmt_pkg.sv
hw/fdsu_rslt_pkg.sv
hw/fdsu_pack_if.sv
hw/fdsu_norm_pack.sv
hw/fdsu_denorm_pack.sv
hw/fdsu_result_select.sv
hw/fdsu_pack_top.sv
tests/fdsu_pack_props.sv
tests/fdsu_pack_tb.sv

// File: hw/fdsu_denorm_pack.sv
// ----------------------------------------------------------
// FDSU denormal result pack
// Right shift into the denormal field, tiny flush, round-up
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

module fdsu_denorm_pack (
  input  fdsu_fmt_pkg::fmt_e          fmt,
  input  logic                        sign,
  input  logic [`FDSU_EXPNT_W-1:0]    expnt,
  input  logic [`FDSU_FRAC_W-1:0]     frac,
  input  logic [1:0]                  potnt_norm,
  input  logic                        denorm_to_tiny,
  fdsu_pack_if.denorm                 pif
);

  logic signed [`FDSU_EXPNT_W-1:0] expnt_s;
  logic                            doub_in_range;
  logic                            sing_in_range;
  logic [5:0]                      shamt;
  logic [`FDSU_FRAC_W-1:0]         frac_shift;
  logic [51:0]                     doub_field;
  logic [22:0]                     sing_field;

  assign expnt_s = expnt;

  assign doub_in_range = (expnt_s <= 1) && (expnt_s >= `FDSU_DOUB_DENORM_MIN);
  assign sing_in_range = (expnt_s <= 1) && (expnt_s >= `FDSU_SING_DENORM_MIN);

  // Shift of 2-e; only meaningful in range, where it spans 1 to 53
  assign shamt      = 6'd2 - expnt[5:0];
  assign frac_shift = frac >> shamt;

  always_comb
  begin
    if (doub_in_range)
    begin
      doub_field = frac_shift[51:0];
    end
    else
    begin
      doub_field = denorm_to_tiny ? 52'd1 : 52'd0;
    end
  end

  // Single keeps the top 23 bits of the same shift
  always_comb
  begin
    if (sing_in_range)
    begin
      sing_field = frac_shift[51:29];
    end
    else
    begin
      sing_field = denorm_to_tiny ? 23'd1 : 23'd0;
    end
  end

  always_comb
  begin
    if (fmt == fdsu_fmt_pkg::FMT_DOUBLE)
    begin
      pif.denorm_result = {sign, 11'h000, doub_field};
    end
    else
    begin
      pif.denorm_result = {32'hffff_ffff, sign, 8'h00, sing_field};
    end
  end

  // Rounding carried the denormal into the smallest normal
  assign pif.denorm_potnt_norm = (potnt_norm[1] && frac[53]) ||
                                 (potnt_norm[0] && frac[54]);

endmodule

// File: hw/fdsu_fmt_pkg.sv
// ----------------------------------------------------------
// FDSU floating-point format types
// ----------------------------------------------------------
package fdsu_fmt_pkg;

  // Result precision; single results are NaN-boxed to 64 bits
  typedef enum logic {
    FMT_DOUBLE = 1'b0,
    FMT_SINGLE = 1'b1
  } fmt_e;

endpackage

// File: hw/fdsu_norm_pack.sv
// ----------------------------------------------------------
// FDSU normal result pack
// Exponent adjust, fraction alignment, carry over/underflow
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

module fdsu_norm_pack (
  input  fdsu_fmt_pkg::fmt_e          fmt,
  input  logic                        sign,
  input  logic [`FDSU_EXPNT_W-1:0]    expnt,
  input  logic [`FDSU_FRAC_W-1:0]     frac,
  input  logic                        potnt_of,
  input  logic                        potnt_uf,
  input  fdsu_rslt_pkg::rslt_class_e  cls,
  fdsu_pack_if.norm                   pif
);

  logic [`FDSU_EXPNT_W-1:0] expnt_inc;
  logic [`FDSU_EXPNT_W-1:0] expnt_rst;
  logic [51:0]              frac_52;
  logic                     carry_any;
  logic                     cls_norm;

  // Exponent correction from the two carry bits
  always_comb
  begin
    case (frac[54:53])
      2'b00:   expnt_inc = '1;
      2'b01:   expnt_inc = '0;
      default: expnt_inc = `FDSU_EXPNT_W'(1);
    endcase
  end

  assign expnt_rst = expnt + expnt_inc;

  // Fraction alignment, hidden bit dropped
  always_comb
  begin
    case (frac[54:53])
      2'b00:   frac_52 = frac[51:0];
      2'b01:   frac_52 = frac[52:1];
      default: frac_52 = frac[53:2];
    endcase
  end

  always_comb
  begin
    if (fmt == fdsu_fmt_pkg::FMT_DOUBLE)
    begin
      pif.norm_result = {sign, expnt_rst[10:0], frac_52};
    end
    else
    begin
      pif.norm_result = {32'hffff_ffff, sign, expnt_rst[7:0], frac_52[51:29]};
    end
  end

  assign carry_any = |frac[54:53];
  assign cls_norm  = (cls == fdsu_rslt_pkg::CLS_NORM);

  // Rounding carry pushes past the max exponent, or failed to lift a tiny one
  assign pif.of_plus = potnt_of && carry_any && cls_norm;
  assign pif.uf_plus = potnt_uf && !carry_any && cls_norm;

endmodule

// File: hw/fdsu_pack_defines.svh
// ----------------------------------------------------------
// FDSU result pack widths and denormal shifter limits
// ----------------------------------------------------------
`ifndef FDSU_PACK_DEFINES_SVH
`define FDSU_PACK_DEFINES_SVH

// Two carry bits above the 53-bit significand
`define FDSU_FRAC_W 55

// Signed exponent, wide enough for over/underflow
`define FDSU_EXPNT_W 13

`define FDSU_RESULT_W 64

// nv, dz, of, uf, nx
`define FDSU_EXPT_W 5

// Lowest exponents the denormal shifter still represents
`define FDSU_DOUB_DENORM_MIN (-51)
`define FDSU_SING_DENORM_MIN (-22)

`endif

// File: hw/fdsu_pack_if.sv
// ----------------------------------------------------------
// FDSU pack paths to result selector
// Normal and denormal packed results with their side flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

interface fdsu_pack_if;

  // Normal path
  logic [`FDSU_RESULT_W-1:0] norm_result;
  logic                      of_plus;
  logic                      uf_plus;

  // Denormal path
  logic [`FDSU_RESULT_W-1:0] denorm_result;
  logic                      denorm_potnt_norm;

  modport norm (
    output norm_result,
    output of_plus,
    output uf_plus
  );

  modport denorm (
    output denorm_result,
    output denorm_potnt_norm
  );

  modport sel (
    input norm_result,
    input of_plus,
    input uf_plus,
    input denorm_result,
    input denorm_potnt_norm
  );

endinterface

// File: hw/fdsu_pack_top.sv
// ----------------------------------------------------------
// FDSU result pack stage top level
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

module fdsu_pack_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  logic                        fmt,
  input  logic [2:0]                  cls,
  input  logic                        sign,
  input  logic [`FDSU_EXPNT_W-1:0]    expnt,
  input  logic [`FDSU_FRAC_W-1:0]     frac,
  input  logic                        qnan_sign,
  input  logic [51:0]                 qnan_frac,
  input  logic [1:0]                  potnt_norm,
  input  logic                        potnt_of,
  input  logic                        potnt_uf,
  input  logic                        of_rst_lfn,
  input  logic                        denorm_to_tiny,
  input  logic [`FDSU_EXPT_W-1:0]     expt_in,
  output logic                        out_valid,
  output logic [`FDSU_RESULT_W-1:0]   out_result,
  output logic [`FDSU_EXPT_W-1:0]     out_expt
);

  fdsu_pack_if pif ();

  fdsu_norm_pack fdsu_norm_pack_inst (
    .fmt      (fdsu_fmt_pkg::fmt_e'(fmt)),
    .sign     (sign),
    .expnt    (expnt),
    .frac     (frac),
    .potnt_of (potnt_of),
    .potnt_uf (potnt_uf),
    .cls      (fdsu_rslt_pkg::rslt_class_e'(cls)),
    .pif      (pif.norm)
  );

  fdsu_denorm_pack fdsu_denorm_pack_inst (
    .fmt            (fdsu_fmt_pkg::fmt_e'(fmt)),
    .sign           (sign),
    .expnt          (expnt),
    .frac           (frac),
    .potnt_norm     (potnt_norm),
    .denorm_to_tiny (denorm_to_tiny),
    .pif            (pif.denorm)
  );

  fdsu_result_select fdsu_result_select_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .fmt        (fdsu_fmt_pkg::fmt_e'(fmt)),
    .cls        (fdsu_rslt_pkg::rslt_class_e'(cls)),
    .sign       (sign),
    .qnan_sign  (qnan_sign),
    .qnan_frac  (qnan_frac),
    .of_rst_lfn (of_rst_lfn),
    .expt_in    (expt_in),
    .pif        (pif.sel),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_expt   (out_expt)
  );

endmodule

// File: hw/fdsu_result_select.sv
// ----------------------------------------------------------
// FDSU result select and output register
// Special encodings, final result mux, flag correction
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

module fdsu_result_select (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  fdsu_fmt_pkg::fmt_e                 fmt,
  input  fdsu_rslt_pkg::rslt_class_e         cls,
  input  logic                               sign,
  input  logic                               qnan_sign,
  input  logic [51:0]                        qnan_frac,
  input  logic                               of_rst_lfn,
  input  fdsu_rslt_pkg::expt_t               expt_in,
  fdsu_pack_if.sel                           pif,
  output logic                               out_valid,
  output logic [`FDSU_RESULT_W-1:0]          out_result,
  output fdsu_rslt_pkg::expt_t               out_expt
);

  logic                      is_double;
  logic [`FDSU_RESULT_W-1:0] rst_zero;
  logic [`FDSU_RESULT_W-1:0] rst_inf;
  logic [`FDSU_RESULT_W-1:0] rst_lfn;
  logic [`FDSU_RESULT_W-1:0] rst_qnan;
  logic [`FDSU_RESULT_W-1:0] result_nxt;
  fdsu_rslt_pkg::expt_t      expt_nxt;

  assign is_double = (fmt == fdsu_fmt_pkg::FMT_DOUBLE);

  assign rst_zero = is_double ? {sign, 63'd0} :
                                {32'hffff_ffff, sign, 31'd0};
  assign rst_inf  = is_double ? {sign, 11'h7ff, 52'd0} :
                                {32'hffff_ffff, sign, 8'hff, 23'd0};
  assign rst_lfn  = is_double ? {sign, 11'h7fe, {52{1'b1}}} :
                                {32'hffff_ffff, sign, 8'hfe, {23{1'b1}}};

  // Quiet bit forced, payload carried from the NaN operand
  assign rst_qnan = is_double ? {qnan_sign, 11'h7ff, 1'b1, qnan_frac[50:0]} :
                                {32'hffff_ffff, qnan_sign, 8'hff, 1'b1, qnan_frac[21:0]};

  always_comb
  begin
    case (cls)
      fdsu_rslt_pkg::CLS_DENORM:
      begin
        // Round-up into the normal range uses the normal encoding
        result_nxt = pif.denorm_potnt_norm ? pif.norm_result : pif.denorm_result;
      end
      fdsu_rslt_pkg::CLS_ZERO: result_nxt = rst_zero;
      fdsu_rslt_pkg::CLS_QNAN: result_nxt = rst_qnan;
      fdsu_rslt_pkg::CLS_INF:  result_nxt = rst_inf;
      fdsu_rslt_pkg::CLS_LFN:  result_nxt = rst_lfn;
      default:
      begin
        if (pif.of_plus)
        begin
          // Rounding mode decides between inf and the largest finite
          result_nxt = of_rst_lfn ? rst_lfn : rst_inf;
        end
        else
        begin
          result_nxt = pif.norm_result;
        end
      end
    endcase
  end

  always_comb
  begin
    expt_nxt.nv = expt_in.nv;
    expt_nxt.dz = expt_in.dz;
    expt_nxt.of = expt_in.of || pif.of_plus;
    // Underflow only counts when inexact
    expt_nxt.uf = expt_in.nx &&
                  ((expt_in.uf && !pif.denorm_potnt_norm) || pif.uf_plus);
    expt_nxt.nx = expt_in.nx || expt_in.of || pif.of_plus;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      out_result <= '0;
      out_expt   <= '0;
    end
    else
    begin
      out_valid <= in_valid;
      // Data holds through idle cycles
      if (in_valid)
      begin
        out_result <= result_nxt;
        out_expt   <= expt_nxt;
      end
    end
  end

endmodule

// File: hw/fdsu_rslt_pkg.sv
// ----------------------------------------------------------
// FDSU result class and exception flag types
// ----------------------------------------------------------
package fdsu_rslt_pkg;

  // Class predicted by the earlier divide/sqrt stages
  typedef enum logic [2:0] {
    CLS_NORM   = 3'd0,
    CLS_DENORM = 3'd1,
    CLS_ZERO   = 3'd2,
    CLS_INF    = 3'd3,
    CLS_LFN    = 3'd4,
    CLS_QNAN   = 3'd5
  } rslt_class_e;

  // Accrued exception flags, nv in the MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } expt_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the FDSU result pack testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module fdsu_pack_tb \
  -o fdsu_pack_sim

sim_out=$(./obj_dir/fdsu_pack_sim)
printf '%s\n' "$sim_out"

# Exit status of grep decides the result of the script
printf '%s\n' "$sim_out" | grep -qx "test passed"

// File: tests/fdsu_pack_props.sv
// ----------------------------------------------------------
// FDSU result pack port properties, bound to the top level
// ----------------------------------------------------------
`timescale 1ns/1ps

module fdsu_pack_props (
  input logic        clk,
  input logic        rst_n,
  input logic        in_valid,
  input logic        fmt,
  input logic        out_valid,
  input logic [63:0] out_result
);

  // Format of the item now held at the output
  logic fmt_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fmt_q <= 1'b0;
    end
    else if (in_valid)
    begin
      fmt_q <= fmt;
    end
  end

  a_valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid))
    else $error("out_valid does not follow in_valid by one cycle");

  a_single_boxed: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && (fmt_q == fdsu_fmt_pkg::FMT_SINGLE)) |-> (out_result[63:32] == 32'hffff_ffff))
    else $error("single result is not NaN-boxed");

endmodule

bind fdsu_pack_top fdsu_pack_props fdsu_pack_props_inst (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .fmt        (fmt),
  .out_valid  (out_valid),
  .out_result (out_result)
);

// File: tests/fdsu_pack_tb.sv
// ----------------------------------------------------------
// FDSU result pack testbench, vectors from a hex file
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fdsu_pack_defines.svh"

module fdsu_pack_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_VEC      = 21;
  localparam int NUM_TESTS    = 5;
  localparam int VEC_WORDS    = 7;
  // Check cycle plus up to 2 random idle cycles per test, with slack
  localparam int IDLE_MARGIN  = 4 * NUM_TESTS;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic                      fmt;
  logic [2:0]                cls;
  logic                      sign;
  logic [`FDSU_EXPNT_W-1:0]  expnt;
  logic [`FDSU_FRAC_W-1:0]   frac;
  logic                      qnan_sign;
  logic [51:0]               qnan_frac;
  logic [1:0]                potnt_norm;
  logic                      potnt_of;
  logic                      potnt_uf;
  logic                      of_rst_lfn;
  logic                      denorm_to_tiny;
  logic [`FDSU_EXPT_W-1:0]   expt_in;
  logic                      out_valid;
  logic [`FDSU_RESULT_W-1:0] out_result;
  logic [`FDSU_EXPT_W-1:0]   out_expt;

  logic [63:0]               vec_mem [0:NUM_VEC*VEC_WORDS-1];
  logic                      exp_valid;
  logic [`FDSU_RESULT_W-1:0] exp_result;
  logic [`FDSU_EXPT_W-1:0]   exp_expt;
  int                        error_count;
  int                        test_errors;
  int                        tests_run;

  fdsu_pack_top fdsu_pack_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .fmt            (fmt),
    .cls            (cls),
    .sign           (sign),
    .expnt          (expnt),
    .frac           (frac),
    .qnan_sign      (qnan_sign),
    .qnan_frac      (qnan_frac),
    .potnt_norm     (potnt_norm),
    .potnt_of       (potnt_of),
    .potnt_uf       (potnt_uf),
    .of_rst_lfn     (of_rst_lfn),
    .denorm_to_tiny (denorm_to_tiny),
    .expt_in        (expt_in),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .out_expt       (out_expt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic string test_name(input logic [3:0] id);
    string name;
    case (id)
      4'd0:    name = "reset values";
      4'd1:    name = "normal results";
      4'd2:    name = "denormal results";
      4'd3:    name = "denormal rounding to normal";
      4'd4:    name = "overflow from rounding carry";
      4'd5:    name = "special classes";
      default: name = "unknown";
    endcase
    return name;
  endfunction

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      error_count++;
      test_errors++;
    end
  endtask

  // Data outputs are compared every cycle, so idle cycles prove the hold
  task check_outputs;
    compare("out_valid", 64'(out_valid), 64'(exp_valid));
    compare("out_result", out_result, exp_result);
    compare("out_expt", 64'(out_expt), 64'(exp_expt));
  endtask

  task drive_idle;
    in_valid       = 1'b0;
    fmt            = 1'b0;
    cls            = 3'd0;
    sign           = 1'b0;
    expnt          = '0;
    frac           = '0;
    qnan_sign      = 1'b0;
    qnan_frac      = '0;
    potnt_norm     = 2'b00;
    potnt_of       = 1'b0;
    potnt_uf       = 1'b0;
    of_rst_lfn     = 1'b0;
    denorm_to_tiny = 1'b0;
    expt_in        = '0;
    exp_valid      = 1'b0;
  endtask

  // Control word holds one field per hex digit
  task apply_vector(input int v);
    logic [63:0] ctrl;
    int          base;
    base           = v * VEC_WORDS;
    ctrl           = vec_mem[base + 1];
    in_valid       = 1'b1;
    fmt            = ctrl[40];
    cls            = ctrl[38:36];
    sign           = ctrl[32];
    qnan_sign      = ctrl[28];
    potnt_norm     = ctrl[25:24];
    potnt_of       = ctrl[20];
    potnt_uf       = ctrl[16];
    of_rst_lfn     = ctrl[12];
    denorm_to_tiny = ctrl[8];
    expt_in        = ctrl[4:0];
    expnt          = vec_mem[base + 2][`FDSU_EXPNT_W-1:0];
    frac           = vec_mem[base + 3][`FDSU_FRAC_W-1:0];
    qnan_frac      = vec_mem[base + 4][51:0];
    exp_valid      = 1'b1;
    exp_result     = vec_mem[base + 5];
    exp_expt       = vec_mem[base + 6][`FDSU_EXPT_W-1:0];
  endtask

  task end_test(input logic [3:0] id);
    $display("Test %0d %s: %0d errors", id, test_name(id), test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  initial
  begin : stimulus
    int          idle;
    logic [3:0]  cur_id;
    logic [3:0]  next_id;
    void'($urandom(32'h8e39));
    error_count = 0;
    test_errors = 0;
    tests_run   = 0;
    exp_result  = '0;
    exp_expt    = '0;
    rst_n       = 1'b0;
    drive_idle();
    $readmemh("tests/fdsu_pack_testdata.hex", vec_mem);
    if (vec_mem[0][3:0] !== 4'd1)
    begin
      $display("Test vectors could not be read from the data file");
      error_count++;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    check_outputs();
    end_test(4'd0);
    rst_n = 1'b1;

    // Vectors of one test run back to back, random idle gap between tests
    for (int v = 0; v < NUM_VEC; v++)
    begin
      @(negedge clk);
      check_outputs();
      apply_vector(v);
      cur_id  = vec_mem[v * VEC_WORDS][3:0];
      next_id = (v == NUM_VEC - 1) ? 4'hf : vec_mem[(v + 1) * VEC_WORDS][3:0];
      if (next_id != cur_id)
      begin
        @(negedge clk);
        check_outputs();
        end_test(cur_id);
        drive_idle();
        idle = $urandom % 3;
        repeat (idle)
        begin
          @(negedge clk);
          check_outputs();
        end
      end
    end

    $display("Summary: %0d tests run, %0d errors", tests_run, error_count);
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  initial
  begin : watchdog
    #((NUM_VEC + IDLE_MARGIN + RESET_CYCLES) * CLK_PERIOD * 2);
    $display("Timeout: the run did not finish in the expected time");
    $display("test failed");
    $finish;
  end

endmodule

// File: tests/fdsu_pack_testdata.hex
// test ctrl(fmt cls sign qnan_sign potnt_norm potnt_of potnt_uf of_rst_lfn tiny expt_in[2])
// expnt frac qnan_frac | expected: out_result out_expt
1 00000000000 03ff 2468ACE02468AC 0 3FF2345670123456 00
1 00100000001 03fe 6AF37BC048D158 0 BFFABCDEF0123456 01
1 00000010001 0401 1FEDCBA9876543 0 400FEDCBA9876543 03
1 10000000000 007f 36969680000000 0 FFFFFFFF3FDA5A5A 00
1 10100000001 0080 491A2B00000000 0 FFFFFFFFC0923456 01
2 01000000003 0001 2468ACE02468AC 0 0002345670123456 03
2 01000000003 1fcd 40000000000000 0 0000000000000002 03
2 01100000003 1ff6 2468ACE02468AC 0 800002468ACE0246 03
2 01000000103 1fcc 7FFFFFFFFFFFFF 0 0000000000000001 03
2 01100000003 1fc4 7FFFFFFFFFFFFF 0 8000000000000000 03
2 11000000003 1ffd 2C000000000000 0 FFFFFFFF000B0000 03
2 11100000103 1fe9 3FFFFFFFFFFFFF 0 FFFFFFFF80000001 03
3 01002000003 0001 20000000000000 0 0010000000000000 01
3 11101000003 0000 40000000000000 0 FFFFFFFF80800000 01
3 01001000003 0001 3FFFFFFFFFFFFE 0 000FFFFFFFFFFFFF 03
4 00000100001 07fe 40000000000000 0 7FF0000000000000 05
4 10100101000 00fe 60000000000000 0 FFFFFFFFFF7FFFFF 05
5 02100000008 0000 00000000000000 0 8000000000000000 08
5 13000000008 0000 00000000000000 0 FFFFFFFF7F800000 08
5 05010000010 0000 00000000000000 0000000000123 FFF8000000000123 10
5 04000000005 0000 00000000000000 0 7FEFFFFFFFFFFFFF 05
